/* sim.f */
+incdir+.
vic_link_pkg.sv
byte_link_if.sv
avr_interface.sv
serial_cross.sv
config_regs.sv
vic_link_top.sv
tb_link_checker.sv
tb_vic_link.sv

/* run_sim.sh */
#!/bin/bash
# build and run the link testbench with verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module tb_vic_link || exit 1
out=$(./obj_dir/Vtb_vic_link)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }

/* tb_vic_link.sv */
`include "vic_link_defs.svh"

module tb_vic_link import vic_link_pkg::*; ();

   localparam int          num_tests  = 60;
   localparam logic [31:0] lfsr_seed  = 32'h7925;
   localparam int          bit_cycles = `CLKS_PER_BIT;
   // 40 bit times per test, the extra 40 tests cover the fixed sequences and rx_busy stalls
   localparam longint      watchdog_time = longint'(num_tests + 40) * 40 * bit_cycles * 20;

   logic        sys_clock = 1'b0;
   logic        clk_dot4x = 1'b0;
   logic        arst_n;
   logic        cclk;
   logic        rx;
   logic        rx_busy;
   logic        tx;
   chip_t       chip;
   logic        ann_write;
   logic        ann_read;
   reg_addr_t   ann_addr;
   byte_t       ann_data;
   int          reply_cnt;
   int          chk_errs;
   int          tb_errs = 0;
   int          reads_sent = 0;
   logic [31:0] lfsr = lfsr_seed;
   reg_addr_t   addr;
   byte_t       data;
   logic        tx_idle; // tx held high the whole time the link was down

   always #10 sys_clock = ~sys_clock;
   always #7 clk_dot4x = ~clk_dot4x; // unrelated to sys_clock

   vic_link_top UUT (
      .sys_clock (sys_clock),
      .clk_dot4x (clk_dot4x),
      .arst_n    (arst_n),
      .cclk      (cclk),
      .rx        (rx),
      .rx_busy   (rx_busy),
      .tx        (tx),
      .chip      (chip)
   );

   tb_link_checker u_check (
      .sys_clock (sys_clock),
      .arst_n    (arst_n),
      .tx        (tx),
      .rx_busy   (rx_busy),
      .chip      (chip),
      .ann_write (ann_write),
      .ann_read  (ann_read),
      .ann_addr  (ann_addr),
      .ann_data  (ann_data),
      .reply_cnt (reply_cnt),
      .err_cnt   (chk_errs)
   );

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1); // galois, taps 32 30 26 25
   endfunction

   function automatic int take_bits(input int nbits);
      int v = 0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = lfsr_step(lfsr); // one step per bit
         v    = (v << 1) | int'(lfsr[0]);
      end
      return v;
   endfunction

   // 8n1 frame, lsb first
   task automatic send_byte(input byte_t b);
      @(negedge sys_clock);
      rx = 1'b0;
      repeat (bit_cycles) @(negedge sys_clock);
      for (int i = 0; i < 8; i++) begin
         rx = b[i];
         repeat (bit_cycles) @(negedge sys_clock);
      end
      rx = 1'b1;
      repeat (bit_cycles) @(negedge sys_clock);
   endtask

   task automatic write_reg(input reg_addr_t a, input byte_t d);
      send_byte({4'b1000, a});
      send_byte(d);
      ann_write = 1'b1;
      ann_addr  = a;
      ann_data  = d;
      @(negedge sys_clock);
      ann_write = 1'b0;
   endtask

   // stall holds rx_busy high across the command and a while after it
   task automatic read_reg(input reg_addr_t a, input logic stall);
      int prev;
      int waited;
      prev = reply_cnt;
      @(negedge sys_clock);
      ann_read = 1'b1;
      ann_addr = a;
      @(negedge sys_clock);
      ann_read = 1'b0;
      reads_sent++;
      if (stall) rx_busy = 1'b1;
      send_byte({4'b0000, a});
      if (stall) begin
         repeat ((16 + take_bits(4)) * bit_cycles) @(negedge sys_clock);
         rx_busy = 1'b0;
      end
      waited = 0;
      while (reply_cnt == prev && waited < 40 * bit_cycles) begin
         @(negedge sys_clock);
         waited++;
      end
      if (reply_cnt == prev) begin
         $display("no reply on tx for the read of register %0d", a);
         tb_errs++;
      end
   endtask

   initial begin
      arst_n    = 1'b0;
      cclk      = 1'b0;
      rx        = 1'b1; // idle line
      rx_busy   = 1'b0;
      ann_write = 1'b0;
      ann_read  = 1'b0;
      ann_addr  = '0;
      ann_data  = '0;
      repeat (3) @(negedge sys_clock);
      arst_n = 1'b1;

      // cclk still low, the link must ignore this read
      send_byte(8'h05);
      tx_idle = 1'b1;
      for (int i = 0; i < 30 * bit_cycles; i++) begin
         @(negedge sys_clock);
         if (tx !== 1'b1 && tx_idle) begin
            $display("Error at %0t: tx expected 1, actual %b", $time, tx);
            tx_idle = 1'b0;
            tb_errs++;
         end
      end
      $display("cclk gating: read before cclk ready, tx %s",
               tx_idle ? "stayed idle" : "did not stay idle");
      cclk = 1'b1;
      repeat (`CCLK_READY_CYCLES + 8) @(negedge sys_clock);
      read_reg(4'd5, 1'b0);

      // write then read back, register 0 first since it drives chip
      write_reg(4'd0, byte_t'(take_bits(8)));
      read_reg(4'd0, 1'b0);
      addr = reg_addr_t'(take_bits(4));
      write_reg(addr, byte_t'(take_bits(8)));
      read_reg(addr, 1'b1); // reply held off by rx_busy

      // random mix, some reads under rx_busy
      for (int t = 0; t < num_tests; t++) begin
         addr = reg_addr_t'(take_bits(4));
         if (take_bits(1) == 1) begin
            data = byte_t'(take_bits(8));
            write_reg(addr, data);
            if (addr == 4'd0) read_reg(reg_addr_t'(take_bits(4)), 1'b0); // chip check
         end else begin
            read_reg(addr, take_bits(2) == 0);
         end
      end

      // second reset, bank should read back all zero
      @(negedge sys_clock);
      arst_n = 1'b0;
      repeat (3) @(negedge sys_clock);
      arst_n = 1'b1;
      repeat (`CCLK_READY_CYCLES + 8) @(negedge sys_clock);
      for (int a = 0; a < `NUM_CFG_REGS; a++) read_reg(reg_addr_t'(a), 1'b0);

      repeat (4 * bit_cycles) @(negedge sys_clock);
      $display("reads %0d, replies %0d, errors %0d", reads_sent, reply_cnt, tb_errs + chk_errs);
      if (tb_errs + chk_errs == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      #(watchdog_time);
      $display("watchdog expired at %0t, the link stopped making progress", $time);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

/* tb_link_checker.sv */
`include "vic_link_defs.svh"

// watches the uart tx line, decodes reply bytes, checks them against a register model
module tb_link_checker import vic_link_pkg::*; (
   input  logic      sys_clock,
   input  logic      arst_n,
   input  logic      tx,
   input  logic      rx_busy,
   input  chip_t     chip,
   input  logic      ann_write, // testbench finished sending a write
   input  logic      ann_read,  // testbench is sending a read, one reply due
   input  reg_addr_t ann_addr,
   input  byte_t     ann_data,
   output int        reply_cnt,
   output int        err_cnt
);

   localparam int n = `CLKS_PER_BIT;

   byte_t     model [`NUM_CFG_REGS];
   byte_t     exp_q [$];  // expected reply values, oldest first
   reg_addr_t addr_q [$];
   logic      in_frame = 1'b0;
   int        cnt = 0;    // cycles since the start bit was seen
   int        bit_idx = 0;
   byte_t     shreg = '0;
   int        replies = 0;
   int        errors = 0;

   assign reply_cnt = replies;
   assign err_cnt   = errors;

   // called at the middle of the stop bit
   task automatic check_reply();
      byte_t     exp_val;
      reg_addr_t exp_addr;
      logic      ok;
      if (exp_q.size() == 0) begin
         $display("reply byte 8'h%02h on tx at %0t with no read outstanding", shreg, $time);
         errors++;
      end else begin
         exp_val  = exp_q.pop_front();
         exp_addr = addr_q.pop_front();
         ok       = 1'b1;
         replies++;
         if (tx !== 1'b1) begin
            $display("Error at %0t: tx stop bit expected 1, actual %b", $time, tx);
            ok = 1'b0;
         end
         if (shreg !== exp_val) begin
            $display("Error at %0t: tx expected 8'h%02h, actual 8'h%02h", $time, exp_val, shreg);
            ok = 1'b0;
         end
         // chip follows register 0 bits 1..0
         if (chip !== model[0][1:0]) begin
            $display("Error at %0t: chip expected %0d, actual %0d", $time, model[0][1:0], chip);
            ok = 1'b0;
         end
         if (!ok) errors++;
         $display("test %0d: read of reg %0d returned 8'h%02h, %s", replies, exp_addr, shreg,
                  ok ? "ok" : "wrong");
      end
   endtask

   always @(posedge sys_clock) begin
      if (!arst_n) begin
         foreach (model[i]) model[i] = '0; // bank comes out of reset cleared
         exp_q.delete();
         addr_q.delete();
         in_frame = 1'b0;
      end else begin
         if (ann_write) model[ann_addr] = ann_data;
         if (ann_read) begin
            exp_q.push_back(model[ann_addr]); // value at the time the read goes out
            addr_q.push_back(ann_addr);
         end
         if (!in_frame) begin
            if (tx == 1'b0) begin // start bit
               in_frame = 1'b1;
               cnt      = 0;
               bit_idx  = 0;
               if (rx_busy) begin
                  $display("start bit on tx at %0t while rx_busy was high", $time);
                  errors++;
               end
            end
         end else begin
            cnt++;
            if (cnt == n * (bit_idx + 1) + n / 2) begin // middle of the next bit
               if (bit_idx < 8) begin
                  shreg = {tx, shreg[7:1]}; // lsb first
                  bit_idx++;
               end else begin
                  in_frame = 1'b0;
                  check_reply();
               end
            end
         end
      end
   end

endmodule

/* vic_link_top.sv */
module vic_link_top import vic_link_pkg::*; (
   input  logic  sys_clock,
   input  logic  clk_dot4x,  // 4x dot clock, unrelated to sys_clock
   input  logic  arst_n,
   input  logic  cclk,       // from mcu
   input  logic  rx,         // from mcu
   input  logic  rx_busy,    // from mcu, its receive buffer is full
   output logic  tx,         // to mcu
   output chip_t chip
);

   byte_t cmd_data;
   logic  cmd_new;
   byte_t reply_data;
   logic  reply_new;
   logic  reply_busy;

   byte_link_if link ();

   // uart side, sys_clock
   avr_interface u_avr (
      .sys_clock (sys_clock),
      .arst_n    (arst_n),
      .cclk      (cclk),
      .rx        (rx),
      .rx_busy   (rx_busy),
      .tx        (tx),
      .link      (link)
   );

   serial_cross u_cross (
      .sys_clock  (sys_clock),
      .clk_dot4x  (clk_dot4x),
      .arst_n     (arst_n),
      .link       (link),
      .cmd_data   (cmd_data),
      .cmd_new    (cmd_new),
      .reply_data (reply_data),
      .reply_new  (reply_new),
      .reply_busy (reply_busy)
   );

   // register bank, clk_dot4x
   config_regs u_regs (
      .clk_dot4x  (clk_dot4x),
      .arst_n     (arst_n),
      .cmd_data   (cmd_data),
      .cmd_new    (cmd_new),
      .reply_data (reply_data),
      .reply_new  (reply_new),
      .reply_busy (reply_busy),
      .chip       (chip)
   );

endmodule

/* config_regs.sv */
`include "vic_link_defs.svh"

module config_regs import vic_link_pkg::*; (
   input  logic  clk_dot4x,
   input  logic  arst_n,
   input  byte_t cmd_data,   // byte from the mcu
   input  logic  cmd_new,
   output byte_t reply_data, // register value for a read
   output logic  reply_new,
   input  logic  reply_busy, // previous reply not yet sent
   output chip_t chip
);

   cmd_state_t state;
   reg_addr_t  cur_addr;                 // target of the command in progress
   reg_addr_t  cmd_addr;
   byte_t      cfg_regs [`NUM_CFG_REGS];

   assign cmd_addr = cmd_data[3:0]; // same field for reads and writes

   always_ff @(posedge clk_dot4x or negedge arst_n) begin
      if (!arst_n) begin
         state      <= wait_cmd;
         cur_addr   <= '0;
         reply_new  <= 1'b0;
         reply_data <= '0;
         cfg_regs   <= '{default: '0};
      end else begin
         reply_new <= 1'b0;
         case (state)
            wait_cmd: begin
               if (cmd_new) begin
                  cur_addr <= cmd_addr;
                  if (cmd_data[7]) begin
                     state <= wait_data; // write, data byte follows
                  end else if (!reply_busy) begin
                     // return path free, answer right away
                     reply_data <= cfg_regs[cmd_addr];
                     reply_new  <= 1'b1;
                  end else begin
                     state <= send_reply;
                  end
               end
            end
            wait_data: begin
               if (cmd_new) begin
                  cfg_regs[cur_addr] <= cmd_data;
                  state              <= wait_cmd;
               end
            end
            send_reply: begin
               // anything arriving here is dropped
               if (!reply_busy) begin
                  reply_data <= cfg_regs[cur_addr];
                  reply_new  <= 1'b1;
                  state      <= wait_cmd;
               end
            end
            default: state <= wait_cmd;
         endcase
      end
   end

   assign chip = cfg_regs[0][1:0]; // chip model select

endmodule

/* serial_cross.sv */
`include "vic_link_defs.svh"

module serial_cross import vic_link_pkg::*; (
   input  logic          sys_clock,
   input  logic          clk_dot4x,
   input  logic          arst_n,
   byte_link_if.vic_side link,
   output byte_t         cmd_data,   // received byte, dot domain
   output logic          cmd_new,
   input  byte_t         reply_data, // reply byte from the register bank
   input  logic          reply_new,
   output logic          reply_busy  // reply still on its way out
);

   localparam int unsigned ss = `SYNC_STAGES;

   logic [ss-1:0] sys_rst_sync, dot_rst_sync;
   logic          sys_rst_n, dot_rst_n;

   byte_t         fwd_data;  // sys side copy of the rx byte
   logic          fwd_tog;
   logic [ss-1:0] fwd_sync;
   logic          fwd_seen;
   logic          fwd_edge;

   byte_t         rev_data;  // dot side copy of the reply
   logic          rev_tog;
   logic [ss-1:0] rev_sync;
   logic          rev_seen;
   logic          rev_edge;
   logic          rev_pend;  // reply waiting for the transmitter
   byte_t         tx_hold;
   logic          tx_go;
   logic          tx_sent;   // transmitter took our byte

   logic          done_tog;
   logic [ss-1:0] done_sync;
   logic          done_seen;
   logic          done_edge;

   // reset asserts at once and releases on each domain's own clock
   always_ff @(posedge sys_clock or negedge arst_n) begin
      if (!arst_n) sys_rst_sync <= '0;
      else sys_rst_sync <= {sys_rst_sync[ss-2:0], 1'b1};
   end
   always_ff @(posedge clk_dot4x or negedge arst_n) begin
      if (!arst_n) dot_rst_sync <= '0;
      else dot_rst_sync <= {dot_rst_sync[ss-2:0], 1'b1};
   end
   assign sys_rst_n = sys_rst_sync[ss-1];
   assign dot_rst_n = dot_rst_sync[ss-1];

   assign rev_edge  = rev_sync[ss-1] ^ rev_seen;
   assign tx_go     = rev_pend && !link.tx_busy;
   assign fwd_edge  = fwd_sync[ss-1] ^ fwd_seen;
   assign done_edge = done_sync[ss-1] ^ done_seen;

   always_ff @(posedge sys_clock or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         fwd_tog  <= 1'b0;
         rev_sync <= '0;
         rev_seen <= 1'b0;
         rev_pend <= 1'b0;
         tx_sent  <= 1'b0;
         done_tog <= 1'b0;
      end else begin
         if (link.rx_new) fwd_tog <= ~fwd_tog;
         rev_sync <= {rev_sync[ss-2:0], rev_tog};
         rev_seen <= rev_sync[ss-1];
         if (rev_edge) rev_pend <= 1'b1;
         else if (tx_go) rev_pend <= 1'b0;
         // tx_busy rises the cycle after tx_go, then falls at end of stop bit
         if (tx_go) begin
            tx_sent <= 1'b1;
         end else if (tx_sent && !link.tx_busy) begin
            tx_sent  <= 1'b0;
            done_tog <= ~done_tog;
         end
      end
   end

   always_ff @(posedge sys_clock) begin
      if (link.rx_new) fwd_data <= link.rx_data;
      if (rev_edge) tx_hold <= rev_data; // rev_data settled long before the toggle
   end

   assign link.tx_data = tx_hold;
   assign link.tx_new  = tx_go;

   always_ff @(posedge clk_dot4x or negedge dot_rst_n) begin
      if (!dot_rst_n) begin
         fwd_sync   <= '0;
         fwd_seen   <= 1'b0;
         cmd_new    <= 1'b0;
         rev_tog    <= 1'b0;
         done_sync  <= '0;
         done_seen  <= 1'b0;
         reply_busy <= 1'b0;
      end else begin
         fwd_sync  <= {fwd_sync[ss-2:0], fwd_tog};
         fwd_seen  <= fwd_sync[ss-1];
         cmd_new   <= fwd_edge;
         if (reply_new) rev_tog <= ~rev_tog;
         done_sync <= {done_sync[ss-2:0], done_tog};
         done_seen <= done_sync[ss-1];
         if (reply_new) reply_busy <= 1'b1;
         else if (done_edge) reply_busy <= 1'b0;
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (fwd_edge) cmd_data <= fwd_data;
      if (reply_new) rev_data <= reply_data;
   end

endmodule

/* avr_interface.sv */
`include "vic_link_defs.svh"

module avr_interface import vic_link_pkg::*; (
   input  logic          sys_clock,
   input  logic          arst_n,
   input  logic          cclk,    // mcu config done
   input  logic          rx,      // serial from mcu
   input  logic          rx_busy, // mcu receive buffer full
   output logic          tx,      // serial to mcu
   byte_link_if.mcu_side link
);

   localparam int unsigned ss    = `SYNC_STAGES;
   localparam int unsigned cnt_w = $clog2(`CLKS_PER_BIT);
   localparam int unsigned rdy_w = $clog2(`CCLK_READY_CYCLES + 1);
   localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`CLKS_PER_BIT - 1);
   localparam logic [cnt_w-1:0] half_cnt = cnt_w'(`CLKS_PER_BIT / 2 - 1);

   logic [ss-1:0]    cclk_sync, rx_sync, busy_sync;
   logic             cclk_s, rx_s, busy_s;
   logic [rdy_w-1:0] rdy_cnt;
   logic             link_ready;

   uart_state_t      rx_state;
   logic [cnt_w-1:0] rx_cnt;
   logic [2:0]       rx_bit;
   byte_t            rx_shift;
   logic             rx_new_q;

   uart_state_t      tx_state;
   logic [cnt_w-1:0] tx_cnt;
   logic [2:0]       tx_bit;
   byte_t            tx_shift;
   logic             tx_pend;  // byte accepted, mcu said hold off
   logic             tx_line;

   // all three mcu lines are asynchronous to us
   always_ff @(posedge sys_clock or negedge arst_n) begin
      if (!arst_n) begin
         cclk_sync <= '0;
         rx_sync   <= '1; // idle line is high
         busy_sync <= '0;
      end else begin
         cclk_sync <= {cclk_sync[ss-2:0], cclk};
         rx_sync   <= {rx_sync[ss-2:0], rx};
         busy_sync <= {busy_sync[ss-2:0], rx_busy};
      end
   end
   assign cclk_s = cclk_sync[ss-1];
   assign rx_s   = rx_sync[ss-1];
   assign busy_s = busy_sync[ss-1];

   // any low on cclk restarts the count
   always_ff @(posedge sys_clock or negedge arst_n) begin
      if (!arst_n) begin
         rdy_cnt    <= '0;
         link_ready <= 1'b0;
      end else if (!cclk_s) begin
         rdy_cnt    <= '0;
         link_ready <= 1'b0;
      end else if (!link_ready) begin
         if (rdy_cnt == rdy_w'(`CCLK_READY_CYCLES - 1))
            link_ready <= 1'b1;
         else
            rdy_cnt <= rdy_cnt + 1'b1;
      end
   end

   // receiver, samples each bit at its middle
   always_ff @(posedge sys_clock or negedge arst_n) begin
      if (!arst_n) begin
         rx_state <= idle;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_new_q <= 1'b0;
      end else begin
         rx_new_q <= 1'b0;
         case (rx_state)
            idle: begin
               rx_cnt <= '0;
               rx_bit <= '0;
               if (link_ready && !rx_s) rx_state <= start;
            end
            start: begin
               if (rx_cnt == half_cnt) begin
                  rx_cnt   <= '0;
                  rx_state <= rx_s ? idle : data; // glitch, not a start bit
               end else begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
            data: begin
               if (rx_cnt == last_cnt) begin
                  rx_cnt <= '0;
                  rx_bit <= rx_bit + 1'b1;
                  if (rx_bit == 3'd7) rx_state <= stop;
               end else begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
            stop: begin
               if (rx_cnt == last_cnt) begin
                  rx_new_q <= rx_s; // drop the byte on a framing error
                  rx_state <= idle;
               end else begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
            default: rx_state <= idle;
         endcase
      end
   end

   always_ff @(posedge sys_clock) begin
      if (rx_state == data && rx_cnt == last_cnt)
         rx_shift <= {rx_s, rx_shift[7:1]}; // lsb arrives first
   end

   assign link.rx_data = rx_shift;
   assign link.rx_new  = rx_new_q;

   // transmitter
   always_ff @(posedge sys_clock or negedge arst_n) begin
      if (!arst_n) begin
         tx_state <= idle;
         tx_cnt   <= '0;
         tx_bit   <= '0;
         tx_pend  <= 1'b0;
         tx_line  <= 1'b1;
      end else begin
         case (tx_state)
            idle: begin
               tx_cnt <= '0;
               tx_bit <= '0;
               if ((link.tx_new || tx_pend) && !busy_s) begin
                  tx_state <= start;
                  tx_line  <= 1'b0;
                  tx_pend  <= 1'b0;
               end else if (link.tx_new) begin
                  tx_pend <= 1'b1;
               end
            end
            start: begin
               if (tx_cnt == last_cnt) begin
                  tx_cnt   <= '0;
                  tx_line  <= tx_shift[0];
                  tx_state <= data;
               end else begin
                  tx_cnt <= tx_cnt + 1'b1;
               end
            end
            data: begin
               if (tx_cnt == last_cnt) begin
                  tx_cnt <= '0;
                  tx_bit <= tx_bit + 1'b1;
                  if (tx_bit == 3'd7) begin
                     tx_line  <= 1'b1; // stop bit
                     tx_state <= stop;
                  end else begin
                     tx_line <= tx_shift[1]; // next bit before the shift lands
                  end
               end else begin
                  tx_cnt <= tx_cnt + 1'b1;
               end
            end
            stop: begin
               if (tx_cnt == last_cnt) tx_state <= idle;
               else tx_cnt <= tx_cnt + 1'b1;
            end
            default: tx_state <= idle;
         endcase
      end
   end

   always_ff @(posedge sys_clock) begin
      if (tx_state == idle && link.tx_new)
         tx_shift <= link.tx_data;
      else if (tx_state == data && tx_cnt == last_cnt)
         tx_shift <= {1'b1, tx_shift[7:1]};
   end

   assign tx           = tx_line;
   assign link.tx_busy = !link_ready || tx_pend || (tx_state != idle);

endmodule

/* byte_link_if.sv */
// byte streams between the uart side and the clock crossing
// everything here lives in the sys_clock domain
interface byte_link_if import vic_link_pkg::*; ();

   byte_t rx_data; // last byte off the uart
   logic  rx_new;  // single cycle strobe for rx_data
   byte_t tx_data; // byte going out
   logic  tx_new;  // single cycle request to send tx_data
   logic  tx_busy; // transmitter occupied or link not up yet

   // uart side produces received bytes and the busy level
   modport mcu_side (
      output rx_data,
      output rx_new,
      output tx_busy,
      input  tx_data,
      input  tx_new
   );

   // crossing side consumes received bytes and requests sends
   modport vic_side (
      input  rx_data,
      input  rx_new,
      input  tx_busy,
      output tx_data,
      output tx_new
   );

endinterface

/* vic_link_pkg.sv */
package vic_link_pkg;

   typedef logic [7:0] byte_t;     // one uart byte
   typedef logic [3:0] reg_addr_t; // config register index
   typedef logic [1:0] chip_t;     // chip model code from register 0

   // shared by the uart receiver and transmitter
   typedef enum logic [1:0] {
      idle,  // line high, nothing going on
      start, // start bit
      data,  // eight data bits, lsb first
      stop   // stop bit
   } uart_state_t;

   // command decoder in the register bank
   typedef enum logic [1:0] {
      wait_cmd,  // expecting a command byte
      wait_data, // write command seen, expecting its data byte
      send_reply // read answer held until the return path is free
   } cmd_state_t;

endpackage

/* vic_link_defs.svh */
`ifndef VIC_LINK_DEFS_SVH
`define VIC_LINK_DEFS_SVH

// uart bit period in sys_clock cycles
// kept short so simulation runs fast
`define CLKS_PER_BIT 8

// cclk has to stay high this many cycles before the mcu is trusted
`define CCLK_READY_CYCLES 16

`define NUM_CFG_REGS 16 // size of the dot domain register bank

// flops per synchronizer chain
// two is enough at these clock rates
`define SYNC_STAGES 2

`endif
